/* vga_timing_pkg.sv */
// ------------------------------------------------
// 640x480 display timing in clk cycles and lines
// shared by the timing generator and the renderer
// ------------------------------------------------
package vga_timing_pkg;

    // horizontal, two clk cycles per pixel
    localparam int h_active = 1280;
    localparam int h_front  = 32;
    localparam int h_sync   = 192;
    localparam int h_back   = 96;
    localparam int h_total  = h_active + h_front + h_sync + h_back;   // 1600

    // vertical, in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;
    localparam int v_total  = v_active + v_front + v_sync + v_back;   // 525

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

endpackage

/* sprite_pkg.sv */
// ------------------------------------------------
// sprite geometry, colour types and register word
// ------------------------------------------------
package sprite_pkg;

    localparam int sprite_dim   = 16;    // edge in pixels
    localparam int sprite_count = 4;
    localparam int rom_depth    = 1024;  // sprite_count * 16 * 16 bytes

    typedef logic [9:0]  rom_addr_t;
    typedef logic [7:0]  color_index_t;
    typedef logic [23:0] rgb_t;          // red in top byte
    typedef logic [11:0] coord_t;

    typedef struct packed {
        logic [7:0] rsvd;
        rgb_t       color;
    } bg_word_t;

    typedef struct packed {
        coord_t     x;       // 31:20
        coord_t     y;       // 19:8
        logic [5:0] sprite;  // 7:2, taken mod sprite_count
        logic       active;
        logic       rsvd;
    } obj_word_t;

    // address 0 holds the background, 1..n the object table
    typedef union packed {
        bg_word_t  bg;
        obj_word_t obj;
    } reg_word_u;

    localparam rgb_t bg_reset_color = 24'h008000;

endpackage

/* vga_timing.sv */
// ------------------------------------------------
// scan counters with hs, vs, blank and pixel clock
// ------------------------------------------------
`timescale 1ns/1ns

module vga_timing import vga_timing_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    hs,
    output logic    vs,
    output logic    blank_n,
    output logic    pix_clk
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == hcount_t'(h_total - 1));
    assign end_of_frame = (vcount == vcount_t'(v_total - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // steps once per line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (end_of_line) begin
            if (end_of_frame) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    assign hs = !(hcount >= h_active + h_front && hcount < h_active + h_front + h_sync);
    assign vs = !(vcount >= v_active + v_front && vcount < v_active + v_front + v_sync);
    assign blank_n = (hcount < h_active) && (vcount < v_active);
    assign pix_clk = hcount[0];   // one pixel per two clk

    a_hcount_range: assert property (@(posedge clk) disable iff (reset)
        hcount < h_total);
    a_vcount_range: assert property (@(posedge clk) disable iff (reset)
        vcount < v_total);

endmodule

/* sprite_regs.sv */
// ------------------------------------------------
// write-only registers, background and object table
// ------------------------------------------------
`timescale 1ns/1ns

module sprite_regs import sprite_pkg::*; #(
    parameter int num_objects = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       chipselect,
    input  logic       write,
    input  logic [6:0] address,
    input  reg_word_u  writedata,
    output rgb_t       bg_color,
    output coord_t     obj_x      [num_objects],
    output coord_t     obj_y      [num_objects],
    output logic [5:0] obj_sprite [num_objects],
    output logic       obj_active [num_objects]
);

    logic wr_en;

    assign wr_en = chipselect & write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bg_color <= bg_reset_color;
        end else if (wr_en && address == 7'd0) begin
            bg_color <= writedata.bg.color;
        end
    end

    // address i+1 loads descriptor i, anything past the table is dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_objects; i++) begin
                obj_x[i]      <= '0;
                obj_y[i]      <= '0;
                obj_sprite[i] <= '0;
                obj_active[i] <= 1'b0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < num_objects; i++) begin
                if (address == 7'(i + 1)) begin
                    obj_x[i]      <= writedata.obj.x;
                    obj_y[i]      <= writedata.obj.y;
                    obj_sprite[i] <= writedata.obj.sprite;
                    obj_active[i] <= writedata.obj.active;
                end
            end
        end
    end

    a_addr_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(address));

endmodule

/* sprite_rom.sv */
// ------------------------------------------------
// sprite pixel memory, one cycle registered read
// ------------------------------------------------
`timescale 1ns/1ns

module sprite_rom import sprite_pkg::*; (
    input  logic         clk,
    input  rom_addr_t    addr,
    output color_index_t index
);

    // sprite * 256 + row * 16 + column
    color_index_t mem [rom_depth];

    initial begin
        $readmemh("sprites.hex", mem);
    end

    always_ff @(posedge clk) begin
        index <= mem[addr];
    end

endmodule

/* palette_lut.sv */
// ------------------------------------------------
// colour index to RGB over the 6x6x6 colour cube
// ------------------------------------------------
`timescale 1ns/1ns

module palette_lut import sprite_pkg::*; (
    input  color_index_t index,
    output rgb_t         rgb
);

    logic [7:0] r_lvl;
    logic [7:0] g_lvl;
    logic [7:0] b_lvl;

    // each level is 0..5, step 0x33
    assign r_lvl = index / 8'd36;
    assign g_lvl = (index / 8'd6) % 8'd6;
    assign b_lvl = index % 8'd6;

    always_comb begin
        if (index < 8'd216) begin
            rgb = {r_lvl * 8'h33, g_lvl * 8'h33, b_lvl * 8'h33};
        end else begin
            rgb = '0;   // upper entries not in the cube
        end
    end

endmodule

/* sprite_renderer.sv */
// ------------------------------------------------
// hit, fetch and select pipeline, three clk deep
// sync and blank travel alongside the pixel data
// ------------------------------------------------
`timescale 1ns/1ns

module sprite_renderer import vga_timing_pkg::*, sprite_pkg::*; #(
    parameter int num_objects = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  hcount_t    hcount,
    input  vcount_t    vcount,
    input  logic       hs,
    input  logic       vs,
    input  logic       blank_n,
    input  logic       pix_clk,
    input  rgb_t       bg_color,
    input  coord_t     obj_x      [num_objects],
    input  coord_t     obj_y      [num_objects],
    input  logic [5:0] obj_sprite [num_objects],
    input  logic       obj_active [num_objects],
    output logic [7:0] vga_r,
    output logic [7:0] vga_g,
    output logic [7:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vga_blank_n,
    output logic       vga_clk
);

    localparam logic [3:0] sync_idle = 4'b1100;   // hs, vs, blank_n, clk

    logic [12:0]            col_w;
    logic [12:0]            row_w;
    logic [num_objects-1:0] hit_c;
    rom_addr_t              addr_c [num_objects];

    logic [num_objects-1:0] hit1;
    logic [num_objects-1:0] hit2;
    rom_addr_t              addr1 [num_objects];
    color_index_t           rom_index [num_objects];
    logic [3:0]             sync1;
    logic [3:0]             sync2;

    logic                   sel_found;
    color_index_t           sel_index;
    rgb_t                   pal_rgb;

    assign col_w = 13'(hcount[10:1]);
    assign row_w = 13'(vcount);

    // stage 1, per object hit test and rom address
    always_comb begin
        logic [12:0] x_off;
        logic [12:0] y_off;
        for (int i = 0; i < num_objects; i++) begin
            x_off = col_w - 13'(obj_x[i]);
            y_off = row_w - 13'(obj_y[i]);
            hit_c[i] = obj_active[i]
                       && col_w >= 13'(obj_x[i]) && x_off < 13'(sprite_dim)
                       && row_w >= 13'(obj_y[i]) && y_off < 13'(sprite_dim);
            addr_c[i] = {obj_sprite[i][1:0], y_off[3:0], x_off[3:0]};  // sprite mod 4
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit1  <= '0;
            hit2  <= '0;
            sync1 <= sync_idle;
            sync2 <= sync_idle;
        end else begin
            hit1  <= hit_c;
            hit2  <= hit1;
            sync1 <= {hs, vs, blank_n, pix_clk};
            sync2 <= sync1;
        end
    end

    always_ff @(posedge clk) begin
        addr1 <= addr_c;
    end

    // stage 2, one rom copy per object
    for (genvar i = 0; i < num_objects; i++) begin : g_rom
        sprite_rom u_rom (
            .clk   (clk),
            .addr  (addr1[i]),
            .index (rom_index[i])
        );
    end

    // stage 3, highest object with an opaque pixel wins
    always_comb begin
        sel_found = 1'b0;
        sel_index = '0;
        for (int i = 0; i < num_objects; i++) begin
            if (hit2[i] && rom_index[i] != '0) begin
                sel_found = 1'b1;
                sel_index = rom_index[i];
            end
        end
    end

    palette_lut u_palette (
        .index (sel_index),
        .rgb   (pal_rgb)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_hs, vga_vs, vga_blank_n, vga_clk} <= sync_idle;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            {vga_hs, vga_vs, vga_blank_n, vga_clk} <= sync2;
            if (!sync2[1]) begin
                {vga_r, vga_g, vga_b} <= '0;
            end else if (sel_found) begin
                {vga_r, vga_g, vga_b} <= pal_rgb;
            end else begin
                {vga_r, vga_g, vga_b} <= bg_color;
            end
        end
    end

    a_blank_black: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> {vga_r, vga_g, vga_b} == '0);

endmodule

/* vga_sprite_top.sv */
// ------------------------------------------------
// sprite overlay engine, register bus in, VGA out
// ------------------------------------------------
`timescale 1ns/1ns

module vga_sprite_top import vga_timing_pkg::*, sprite_pkg::*; #(
    parameter int num_objects = 8   // 1..127
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [6:0]  address,
    input  logic [31:0] writedata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n
);

    rgb_t       bg_color;
    coord_t     obj_x      [num_objects];
    coord_t     obj_y      [num_objects];
    logic [5:0] obj_sprite [num_objects];
    logic       obj_active [num_objects];

    hcount_t    hcount;
    vcount_t    vcount;
    logic       hs;
    logic       vs;
    logic       blank_n;
    logic       pix_clk;

    sprite_regs #(
        .num_objects (num_objects)
    ) u_regs (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .bg_color   (bg_color),
        .obj_x      (obj_x),
        .obj_y      (obj_y),
        .obj_sprite (obj_sprite),
        .obj_active (obj_active)
    );

    vga_timing u_timing (
        .clk     (clk),
        .reset   (reset),
        .hcount  (hcount),
        .vcount  (vcount),
        .hs      (hs),
        .vs      (vs),
        .blank_n (blank_n),
        .pix_clk (pix_clk)
    );

    sprite_renderer #(
        .num_objects (num_objects)
    ) u_renderer (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .hs          (hs),
        .vs          (vs),
        .blank_n     (blank_n),
        .pix_clk     (pix_clk),
        .bg_color    (bg_color),
        .obj_x       (obj_x),
        .obj_y       (obj_y),
        .obj_sprite  (obj_sprite),
        .obj_active  (obj_active),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_clk     (vga_clk)
    );

endmodule

/* tb_vga_sprite.sv */
// ------------------------------------------------
// testbench for the sprite engine, scan model with
// a reference pixel function checked every clk
// ------------------------------------------------
`timescale 1ns/1ns

module tb_vga_sprite import vga_timing_pkg::*, sprite_pkg::*; ();

    localparam int num_objects = 8;
    localparam int max_cycles  = 7 * v_total * h_total;   // 7 frames

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [6:0]  address;
    logic [31:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;

    // model state
    color_index_t sprite_mem [rom_depth];
    rgb_t         sh_bg;
    coord_t       sh_x      [num_objects];
    coord_t       sh_y      [num_objects];
    logic [5:0]   sh_sprite [num_objects];
    logic         sh_active [num_objects];
    int           mh;
    int           mv;
    int           cycles;
    logic [27:0]  exp_pipe [3];
    logic [31:0]  lfsr_state;
    string        test_name;

    vga_sprite_top #(
        .num_objects (num_objects)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic int random_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
        return val;
    endfunction

    function automatic logic [31:0] obj_word(input int x, input int y, input int spr,
                                             input logic act);
        return {12'(x), 12'(y), 6'(spr), act, 1'b0};
    endfunction

    // {hs, vs, blank_n, clk, rgb} for one counter position
    function automatic logic [27:0] expected_out(input int h, input int v);
        logic hs_e;
        logic vs_e;
        logic bl_e;
        logic ck_e;
        rgb_t rgb_e;
        int   col;
        int   ox;
        int   oy;
        int   px;
        int   idx;
        hs_e  = !(h >= 1312 && h < 1504);
        vs_e  = !(v == 490 || v == 491);
        bl_e  = (h < 1280) && (v < 480);
        ck_e  = h % 2;
        rgb_e = '0;
        if (bl_e) begin
            col = h / 2;
            idx = 0;
            for (int i = 0; i < num_objects; i++) begin
                ox = sh_x[i];
                oy = sh_y[i];
                if (sh_active[i] && col >= ox && col < ox + 16 && v >= oy && v < oy + 16) begin
                    px = sprite_mem[(sh_sprite[i] % sprite_count) * 256
                                    + (v - oy) * 16 + (col - ox)];
                    if (px != 0) idx = px;   // later objects win
                end
            end
            if (idx == 0) begin
                rgb_e = sh_bg;
            end else if (idx < 216) begin
                rgb_e = {8'(idx / 36 * 51), 8'((idx / 6) % 6 * 51), 8'(idx % 6 * 51)};
            end
        end
        return {hs_e, vs_e, bl_e, ck_e, rgb_e};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "output mismatch at h=%0d v=%0d", mh, mv);
        end
    endtask

    // one bus write, shadow follows the same address map
    task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
        int idx;
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        idx = int'(addr) - 1;
        if (addr == 7'd0) begin
            sh_bg <= data[23:0];
        end else if (idx < num_objects) begin
            sh_x[idx]      <= data[31:20];
            sh_y[idx]      <= data[19:8];
            sh_sprite[idx] <= data[7:2];
            sh_active[idx] <= data[1];
        end
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
    endtask

    task automatic wait_for_line(input int line);
        @(posedge clk);
        while (mv != line || mh != 0) @(posedge clk);
    endtask

    // model counters and the compare, three clk behind the scan
    always @(posedge clk) begin
        logic [27:0] act;
        if (!reset) begin
            cycles = cycles + 1;
            if (cycles > max_cycles) begin
                $display("Timeout: the test sequence did not finish in %0d cycles", max_cycles);
                $display("Simulation finished: FAIL");
                $fatal(1, "timeout");
            end else begin
                act = {vga_hs, vga_vs, vga_blank_n, vga_clk, vga_r, vga_g, vga_b};
                check_value(test_name, 32'(exp_pipe[2]), 32'(act));
                exp_pipe[2] = exp_pipe[1];
                exp_pipe[1] = exp_pipe[0];
                exp_pipe[0] = expected_out(mh, mv);
                if (mh == h_total - 1) begin
                    mh <= 0;
                    mv <= (mv == v_total - 1) ? 0 : mv + 1;
                end else begin
                    mh <= mh + 1;
                end
            end
        end
    end

    initial begin
        int x0;
        int y0;
        int s0;
        int x1;
        int y1;
        int x2;
        int y2;
        int s2;
        int x3;
        $readmemh("sprites.hex", sprite_mem);
        clk        = 1'b0;
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        sh_bg      = 24'h008000;
        for (int i = 0; i < num_objects; i++) begin
            sh_x[i]      = '0;
            sh_y[i]      = '0;
            sh_sprite[i] = '0;
            sh_active[i] = 1'b0;
        end
        mh         = 0;
        mv         = 0;
        cycles     = 0;
        exp_pipe   = '{3{28'hc000000}};   // idle outputs while the pipe fills
        lfsr_state = 32'hd0ee;
        test_name  = "reset and first frame";
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // all writes land in vertical blanking
        wait_for_line(490);
        test_name <= "background write";
        write_reg(7'd0, {8'h00, 24'h3366cc});

        wait_for_line(490);
        test_name <= "single sprite";
        x0 = 100 + random_bits(8);
        y0 = 100 + random_bits(7);
        s0 = random_bits(2);
        write_reg(7'd1, obj_word(x0, y0, s0, 1'b1));

        wait_for_line(490);
        test_name <= "overlap priority";
        x1 = x0 + 4 + random_bits(3);
        y1 = y0 + 4 + random_bits(3);
        write_reg(7'd1, obj_word(x0, y0, 2, 1'b1));   // solid ramp underneath
        write_reg(7'd6, obj_word(x1, y1, 0, 1'b1));   // checker on top

        wait_for_line(490);
        test_name <= "deactivate and ignored address";
        x2 = 400 + random_bits(7);
        y2 = 300 + random_bits(7);
        s2 = 4 + random_bits(5);
        x3 = 640 + random_bits(8);
        write_reg(7'd6, obj_word(x1, y1, 0, 1'b0));
        write_reg(7'(num_objects + 1), obj_word(200, 200, 2, 1'b1));
        write_reg(7'd3, obj_word(x2, y2, s2, 1'b1));
        write_reg(7'd8, obj_word(x3, 50, 2, 1'b1));

        wait_for_line(490);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sprites.hex */
// colour indices, 16 per sprite row, two rows per line, 00 is transparent
// sprites 0 to 3 in order, 8 lines each (checker, half bars, ramp, frame)
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4 00 b4
01 01 01 01 01 01 01 01 00 00 00 00 00 00 00 00 0e 0e 0e 0e 0e 0e 0e 0e 00 00 00 00 00 00 00 00
1b 1b 1b 1b 1b 1b 1b 1b 00 00 00 00 00 00 00 00 28 28 28 28 28 28 28 28 00 00 00 00 00 00 00 00
35 35 35 35 35 35 35 35 00 00 00 00 00 00 00 00 42 42 42 42 42 42 42 42 00 00 00 00 00 00 00 00
4f 4f 4f 4f 4f 4f 4f 4f 00 00 00 00 00 00 00 00 5c 5c 5c 5c 5c 5c 5c 5c 00 00 00 00 00 00 00 00
69 69 69 69 69 69 69 69 00 00 00 00 00 00 00 00 76 76 76 76 76 76 76 76 00 00 00 00 00 00 00 00
83 83 83 83 83 83 83 83 00 00 00 00 00 00 00 00 90 90 90 90 90 90 90 90 00 00 00 00 00 00 00 00
9d 9d 9d 9d 9d 9d 9d 9d 00 00 00 00 00 00 00 00 aa aa aa aa aa aa aa aa 00 00 00 00 00 00 00 00
b7 b7 b7 b7 b7 b7 b7 b7 00 00 00 00 00 00 00 00 c4 c4 c4 c4 c4 c4 c4 c4 00 00 00 00 00 00 00 00
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff 10 20 30 40 50 60 70 80 90 a0 b0 c0 d0 e0 f0 ff
2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b
2b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b 2b

/* filelist.f */
vga_timing_pkg.sv
sprite_pkg.sv
vga_timing.sv
sprite_regs.sv
sprite_rom.sv
palette_lut.sv
sprite_renderer.sv
vga_sprite_top.sv
tb_vga_sprite.sv

/* Bender.yml */
package:
  name: vga_sprite

sources:
  - files:
      - vga_timing_pkg.sv
      - sprite_pkg.sv
      - vga_timing.sv
      - sprite_regs.sv
      - sprite_rom.sv
      - palette_lut.sv
      - sprite_renderer.sv
      - vga_sprite_top.sv
  - target: simulation
    files:
      - tb_vga_sprite.sv
